/* pkt_fifo.f */
common/pkt_fifo_pkg.sv
common/axis_if.sv
hdl/axis_probe.sv
hdl/pkt_admit.sv
pkt_store/pkt_store.sv
hdl/pkt_fifo_regs.sv
hdl/pkt_fifo_top.sv
+incdir+bench
bench/pkt_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the packet FIFO testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pkt_fifo.f --top-module pkt_fifo_tb \
   -Mdir obj_dir -o pkt_fifo_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/pkt_fifo_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
   exit 0
fi
exit 1

/* bench/pkt_fifo_model.svh */
// Packet FIFO reference model
// Follows every input and output handshake, predicts which packets are
// kept or dropped from the free space rule, and keeps the expected output
// words together with the packet, byte and drop totals

`ifndef PKT_FIFO_MODEL_SVH
`define PKT_FIFO_MODEL_SVH

// words of complete kept packets, in output order
pkt_fifo_pkg::stream_word_t exp_q[$];
// words of the packet still arriving
pkt_fifo_pkg::stream_word_t pend_q[$];
// words held in the store, the open packet included
int          occ = 0;
bit          m_dropping = 1'b0;
int unsigned m_in_pkts = 0;
int unsigned m_in_bytes = 0;
int unsigned m_out_pkts = 0;
int unsigned m_out_bytes = 0;
int unsigned m_drop_pkts = 0;

function automatic int unsigned lane_count(input logic [pkt_fifo_pkg::keep_w-1:0] keep);
   int unsigned n;
   n = 0;
   for (int i = 0; i < pkt_fifo_pkg::keep_w; i++) begin
      if (keep[i]) n++;
   end
   return n;
endfunction

// one input word, seen before any read on the same edge
task automatic model_in(input pkt_fifo_pkg::stream_word_t w);
   m_in_bytes += lane_count(w.tkeep);
   if (w.tlast) m_in_pkts++;
   if (m_dropping) begin
      // rest of a dropped packet
      if (w.tlast) begin
         m_dropping = 1'b0;
         m_drop_pkts++;
      end
   end else if (occ == depth) begin
      // no room, the open packet is thrown away
      occ -= pend_q.size();
      pend_q.delete();
      if (w.tlast) m_drop_pkts++;
      else m_dropping = 1'b1;
   end else begin
      occ++;
      pend_q.push_back(w);
      if (w.tlast) begin
         foreach (pend_q[i]) exp_q.push_back(pend_q[i]);
         pend_q.delete();
      end
   end
endtask

// one output word leaves the store
task automatic model_out(input pkt_fifo_pkg::stream_word_t w);
   occ--;
   m_out_bytes += lane_count(w.tkeep);
   if (w.tlast) m_out_pkts++;
endtask

`endif

/* bench/pkt_fifo_tb.sv */
// Packet FIFO testbench
// Random packets from a fixed seed in free flow, a forwarding latency
// check, an overflow burst against a stalled output, and APB reads of
// the statistics compared with the reference model

`timescale 1ns/1ps

module pkt_fifo_tb;

   localparam int depth  = 64;
   localparam int clk_ns = 8;
   localparam int n_free = 40;
   localparam int n_ovf  = 24;
   // every packet of the run, the forwarding check packet included
   localparam int n_pkts = n_free + 1 + n_ovf;
   localparam int watchdog_ns = (n_pkts * 40 + 2000) * clk_ns;

   logic        aclk = 1'b0;
   logic        rst_n;
   logic        in_tvalid, in_tlast, out_tvalid, out_tready, out_tlast;
   logic [31:0] in_tdata, out_tdata;
   logic [3:0]  in_tkeep, out_tkeep;
   logic [7:0]  paddr;
   logic        psel, penable, pwrite, pready, pslverr;
   logic [31:0] pwdata, prdata;

   integer seed;
   // 0 holds out_tready low, 1 random at 75 percent, 2 always high
   int     tready_mode;
   pkt_fifo_pkg::stream_word_t mon_word, exp_word, in_word;

   `include "pkt_fifo_model.svh"

   pkt_fifo_top #(.fifo_depth(depth)) dut (
      .aclk, .rst_n, .in_tvalid, .in_tdata, .in_tkeep, .in_tlast,
      .out_tvalid, .out_tready, .out_tdata, .out_tkeep, .out_tlast,
      .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
   );

   always #(clk_ns / 2) aclk = ~aclk;

   // --------------------------------------------------
   // error reporting
   // --------------------------------------------------
   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic int rand_range(input int lo, input int hi);
      return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
   endfunction

   // --------------------------------------------------
   // stimulus helpers, all on the falling edge
   // --------------------------------------------------
   task automatic next_cycle();
      @(negedge aclk);
      case (tready_mode)
         0: out_tready = 1'b0;
         1: out_tready = (($random(seed) & 3) != 0);
         default: out_tready = 1'b1;
      endcase
   endtask

   // idle_out asks for out_tvalid low up to the cycle after tlast
   task automatic send_packet(input int len, input int gap, input bit idle_out);
      int lanes;
      for (int i = 0; i <= len; i++) begin
         next_cycle();
         if (idle_out) begin
            assert (!out_tvalid) else report_mismatch("out_tvalid high before packet commit");
         end
         in_tvalid = (i < len);
         in_tlast  = (i == len - 1);
         in_tdata  = $random(seed);
         if (i == len - 1) begin
            lanes    = rand_range(1, pkt_fifo_pkg::keep_w);
            in_tkeep = pkt_fifo_pkg::keep_w'((1 << lanes) - 1);
         end else begin
            in_tkeep = '1;
         end
      end
      repeat (gap) next_cycle();
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      tready_mode = 2;
      while (exp_q.size() != 0 || out_tvalid) begin
         next_cycle();
         waited++;
         if (waited > 2 * depth + 16) abort_run("timeout: output did not drain");
      end
      repeat (4) next_cycle();
   endtask

   task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int waited;
      next_cycle();
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      next_cycle();
      penable = 1'b1;
      waited  = 0;
      while (!pready) begin
         next_cycle();
         waited++;
         if (waited > 8) abort_run("timeout: APB transfer never saw pready");
      end
      rdata = prdata;
      err   = pslverr;
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected,
                            input string name);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(addr, 1'b0, 32'h0, rdata, err);
      assert (!err && rdata == expected) else report_mismatch($sformatf(
         "%s reads %h with pslverr %b, expected %h", name, rdata, err, expected));
   endtask

   task automatic check_all_regs();
      check_reg(pkt_fifo_pkg::reg_in_pkts, m_in_pkts, "in_pkts");
      check_reg(pkt_fifo_pkg::reg_in_bytes, m_in_bytes, "in_bytes");
      check_reg(pkt_fifo_pkg::reg_out_pkts, m_out_pkts, "out_pkts");
      check_reg(pkt_fifo_pkg::reg_out_bytes, m_out_bytes, "out_bytes");
      check_reg(pkt_fifo_pkg::reg_drop_pkts, m_drop_pkts, "drop_pkts");
      check_reg(pkt_fifo_pkg::reg_level, 32'h0, "level");
   endtask

   // --------------------------------------------------
   // handshake monitor, input first so the model sees room before reads
   // --------------------------------------------------
   always @(posedge aclk) begin
      if (rst_n) begin
         if (in_tvalid) begin
            in_word = '{tlast: in_tlast, tkeep: in_tkeep, tdata: in_tdata};
            model_in(in_word);
         end
         if (out_tvalid && out_tready) begin
            mon_word = '{tlast: out_tlast, tkeep: out_tkeep, tdata: out_tdata};
            assert (exp_q.size() != 0) else report_mismatch("output word with none expected");
            exp_word = exp_q.pop_front();
            assert (mon_word == exp_word) else report_mismatch($sformatf(
               "output %h/%h/%b, expected %h/%h/%b", mon_word.tdata, mon_word.tkeep,
               mon_word.tlast, exp_word.tdata, exp_word.tkeep, exp_word.tlast));
            model_out(mon_word);
         end
      end
   end

   initial begin
      #(watchdog_ns);
      $display("timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      int          len;
      int          sent;
      logic [31:0] rdata;
      logic        err;
      seed        = 32'ha4c8_8126;
      tready_mode = 0;
      rst_n       = 1'b0;
      in_tvalid   = 1'b0;
      in_tdata    = '0;
      in_tkeep    = '0;
      in_tlast    = 1'b0;
      out_tready  = 1'b0;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      repeat (2) @(negedge aclk);
      rst_n = 1'b1;

      // free flow with gaps, nothing may be dropped
      tready_mode = 1;
      for (int p = 0; p < n_free; p++) begin
         send_packet(rand_range(1, 12), rand_range(2, 8), 1'b0);
      end
      drain();
      assert (m_drop_pkts == 0) else report_mismatch("free flow predicted a drop");
      check_all_regs();

      // packet held back until its tlast word is stored
      tready_mode = 0;
      send_packet(rand_range(2, 12), 0, 1'b1);
      next_cycle();
      assert (out_tvalid) else report_mismatch("out_tvalid low one cycle after commit");
      drain();

      // overflow against a stalled output
      tready_mode = 0;
      sent = 0;
      for (int p = 0; p < n_ovf; p++) begin
         len = rand_range(1, 12);
         sent += len;
         send_packet(len, 0, 1'b0);
      end
      assert (sent > depth && m_drop_pkts > 0) else report_mismatch(
         $sformatf("overflow burst of %0d words dropped no packet", sent));
      drain();
      check_all_regs();

      // unmapped offsets and ignored writes
      apb_xfer(8'h18, 1'b0, 32'h0, rdata, err);
      assert (err) else report_mismatch("offset 0x18 read without pslverr");
      apb_xfer(8'h80, 1'b0, 32'h0, rdata, err);
      assert (err) else report_mismatch("offset 0x80 read without pslverr");
      apb_xfer(pkt_fifo_pkg::reg_in_pkts, 1'b1, $random(seed), rdata, err);
      apb_xfer(pkt_fifo_pkg::reg_in_bytes, 1'b1, $random(seed), rdata, err);
      apb_xfer(pkt_fifo_pkg::reg_out_pkts, 1'b1, $random(seed), rdata, err);
      apb_xfer(pkt_fifo_pkg::reg_out_bytes, 1'b1, $random(seed), rdata, err);
      apb_xfer(pkt_fifo_pkg::reg_drop_pkts, 1'b1, $random(seed), rdata, err);
      apb_xfer(pkt_fifo_pkg::reg_level, 1'b1, $random(seed), rdata, err);
      check_all_regs();

      $display("TEST OK");
      $finish;
   end

endmodule

/* hdl/pkt_fifo_top.sv */
// Packet-aware synchronous FIFO, top level
// Input stream never stalls. Packets go out only once fully stored,
// overflowing packets are dropped whole. Probes on both streams and an
// APB block expose packet, byte and drop totals plus the store level

`timescale 1ns/1ps

module pkt_fifo_top #(
   parameter int fifo_depth = 64
) (
   input  logic                                 aclk,
   input  logic                                 rst_n,
   // input stream, no tready
   input  logic                                 in_tvalid,
   input  logic [pkt_fifo_pkg::data_w-1:0]      in_tdata,
   input  logic [pkt_fifo_pkg::keep_w-1:0]      in_tkeep,
   input  logic                                 in_tlast,
   // output stream
   output logic                                 out_tvalid,
   input  logic                                 out_tready,
   output logic [pkt_fifo_pkg::data_w-1:0]      out_tdata,
   output logic [pkt_fifo_pkg::keep_w-1:0]      out_tkeep,
   output logic                                 out_tlast,
   // APB
   input  logic [pkt_fifo_pkg::apb_addr_w-1:0]  paddr,
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [31:0]                          pwdata,
   output logic [31:0]                          prdata,
   output logic                                 pready,
   output logic                                 pslverr
);

   localparam int addr_w = $clog2(fifo_depth);

   axis_if in_s ();
   axis_if out_s ();

   logic                            wr_en;
   pkt_fifo_pkg::stream_word_t      wr_word;
   logic                            commit;
   logic                            rollback;
   logic [addr_w:0]                 free_words;
   logic [addr_w:0]                 level;
   logic [pkt_fifo_pkg::cnt_w-1:0]  in_pkts, in_bytes;
   logic [pkt_fifo_pkg::cnt_w-1:0]  out_pkts, out_bytes;
   logic [pkt_fifo_pkg::cnt_w-1:0]  drop_pkts;

   // --------------------------------------------------
   // stream ports onto the interfaces
   // --------------------------------------------------
   assign in_s.tvalid = in_tvalid;
   assign in_s.tdata  = in_tdata;
   assign in_s.tkeep  = in_tkeep;
   assign in_s.tlast  = in_tlast;

   assign out_tvalid   = out_s.tvalid;
   assign out_tdata    = out_s.tdata;
   assign out_tkeep    = out_s.tkeep;
   assign out_tlast    = out_s.tlast;
   assign out_s.tready = out_tready;

   // --------------------------------------------------
   // datapath
   // --------------------------------------------------
   pkt_admit #(.addr_w(addr_w)) admit (
      .aclk, .rst_n, .in_s, .wr_en, .wr_word, .commit, .rollback,
      .free_words, .drop_cnt(drop_pkts)
   );

   pkt_store #(.addr_w(addr_w)) store (
      .aclk, .rst_n, .wr_en, .wr_word, .commit, .rollback,
      .free_words, .out_s, .level
   );

   // statistics on both sides of the store
   axis_probe probe_in (
      .aclk, .rst_n, .axis(in_s), .pkt_cnt(in_pkts), .byte_cnt(in_bytes)
   );

   axis_probe probe_out (
      .aclk, .rst_n, .axis(out_s), .pkt_cnt(out_pkts), .byte_cnt(out_bytes)
   );

   pkt_fifo_regs #(.addr_w(addr_w)) regs (
      .aclk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
      .prdata, .pready, .pslverr, .in_pkts, .in_bytes, .out_pkts,
      .out_bytes, .drop_pkts, .level
   );

endmodule

/* hdl/pkt_fifo_regs.sv */
// Packet FIFO status registers
// APB slave with read-only counters and store level.
// Read data is captured in the setup cycle and the access phase
// completes in its first cycle. Unmapped offsets answer with pslverr

`timescale 1ns/1ps

module pkt_fifo_regs #(
   parameter int addr_w = 6
) (
   input  logic                                 aclk,
   input  logic                                 rst_n,
   input  logic [pkt_fifo_pkg::apb_addr_w-1:0]  paddr,
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [31:0]                          pwdata,
   output logic [31:0]                          prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   input  logic [pkt_fifo_pkg::cnt_w-1:0]       in_pkts,
   input  logic [pkt_fifo_pkg::cnt_w-1:0]       in_bytes,
   input  logic [pkt_fifo_pkg::cnt_w-1:0]       out_pkts,
   input  logic [pkt_fifo_pkg::cnt_w-1:0]       out_bytes,
   input  logic [pkt_fifo_pkg::cnt_w-1:0]       drop_pkts,
   input  logic [addr_w:0]                      level
);

   logic        setup;
   logic [31:0] rd_val;
   logic        unmapped;

   // setup cycle of a transfer
   assign setup = psel && !penable;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------
   always_comb begin
      rd_val   = '0;
      unmapped = 1'b0;
      case (paddr)
         pkt_fifo_pkg::reg_in_pkts:   rd_val = 32'(in_pkts);
         pkt_fifo_pkg::reg_in_bytes:  rd_val = 32'(in_bytes);
         pkt_fifo_pkg::reg_out_pkts:  rd_val = 32'(out_pkts);
         pkt_fifo_pkg::reg_out_bytes: rd_val = 32'(out_bytes);
         pkt_fifo_pkg::reg_drop_pkts: rd_val = 32'(drop_pkts);
         pkt_fifo_pkg::reg_level:     rd_val = 32'(level);
         default:                     unmapped = 1'b1;
      endcase
   end

   // --------------------------------------------------
   // response
   // --------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         // high only for the single access cycle
         pready  <= setup;
         pslverr <= setup && unmapped;
      end
   end

   // all registers are read only, prdata is zero during a write
   always_ff @(posedge aclk) begin
      if (setup) begin
         prdata <= pwrite ? 32'h0 : rd_val;
      end
   end

endmodule

/* pkt_store/pkt_store.sv */
// Packet store
// Word memory with a write pointer, a committed write pointer and a read
// pointer. Only committed words are offered on the output, so a packet
// shows up only once it is complete. Rollback drops uncommitted words.
// The read side is first-word-fall-through

`timescale 1ns/1ps

module pkt_store #(
   parameter int addr_w = 6
) (
   input  logic                        aclk,
   input  logic                        rst_n,
   input  logic                        wr_en,
   input  pkt_fifo_pkg::stream_word_t  wr_word,
   input  logic                        commit,
   input  logic                        rollback,
   output logic [addr_w:0]             free_words,
   axis_if.tx                          out_s,
   output logic [addr_w:0]             level
);

   localparam int depth = 1 << addr_w;

   pkt_fifo_pkg::stream_word_t mem [depth];

   // one extra bit on each pointer tells full from empty
   logic [addr_w:0] wr_ptr;
   logic [addr_w:0] cmt_ptr;
   // committed pointer as seen by the read side, one cycle behind
   logic [addr_w:0] vis_ptr;
   logic [addr_w:0] rd_ptr;
   logic            rd_xfer;
   pkt_fifo_pkg::stream_word_t rd_word;

   // --------------------------------------------------
   // write side
   // --------------------------------------------------
   always_ff @(posedge aclk) begin
      if (wr_en) begin
         mem[wr_ptr[addr_w-1:0]] <= wr_word;
      end
   end

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         cmt_ptr <= '0;
         vis_ptr <= '0;
      end else begin
         if (rollback) begin
            wr_ptr <= cmt_ptr;
         end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // tlast word moves the commit mark past itself
         if (commit) begin
            cmt_ptr <= wr_ptr + 1'b1;
         end
         vis_ptr <= cmt_ptr;
      end
   end

   // room left counts uncommitted words as used
   assign free_words = (addr_w+1)'(depth) - (wr_ptr - rd_ptr);

   // --------------------------------------------------
   // read side
   // --------------------------------------------------
   assign rd_xfer = out_s.tvalid && out_s.tready;

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (rd_xfer) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // head word falls straight through to the output
   assign rd_word      = mem[rd_ptr[addr_w-1:0]];
   assign out_s.tvalid = (rd_ptr != vis_ptr);
   assign out_s.tdata  = rd_word.tdata;
   assign out_s.tkeep  = rd_word.tkeep;
   assign out_s.tlast  = rd_word.tlast;

   assign level = vis_ptr - rd_ptr;

endmodule

/* hdl/pkt_admit.sv */
// Packet admission
// Accepts the never-stalling input stream and decides per packet whether
// it goes into the store. A word that meets a full store rolls back the
// packet written so far and the rest of it is thrown away up to tlast.
// Each thrown-away packet is counted once, at its last word

`timescale 1ns/1ps

module pkt_admit #(
   parameter int addr_w = 6
) (
   input  logic                               aclk,
   input  logic                               rst_n,
   axis_if.rx                                 in_s,
   output logic                               wr_en,
   output pkt_fifo_pkg::stream_word_t         wr_word,
   output logic                               commit,
   output logic                               rollback,
   input  logic [addr_w:0]                    free_words,
   output logic [pkt_fifo_pkg::cnt_w-1:0]     drop_cnt
);

   logic xfer;
   logic full;
   // set while the rest of a packet is being discarded
   logic dropping;

   // the source ignores back-pressure, so the input is always ready
   assign in_s.tready = 1'b1;

   assign xfer = in_s.tvalid && in_s.tready;
   assign full = (free_words == '0);

   // word as it goes to the store
   assign wr_word.tlast = in_s.tlast;
   assign wr_word.tkeep = in_s.tkeep;
   assign wr_word.tdata = in_s.tdata;

   // --------------------------------------------------
   // store control
   // --------------------------------------------------
   // write while the packet is still healthy and there is room
   assign wr_en    = xfer && !dropping && !full;
   // last word of a kept packet closes it in the store
   assign commit   = wr_en && in_s.tlast;
   // first word that hits a full store undoes the partial packet
   assign rollback = xfer && !dropping && full;

   // --------------------------------------------------
   // drop state and drop counter
   // --------------------------------------------------
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         dropping <= 1'b0;
         drop_cnt <= '0;
      end else if (xfer) begin
         if (dropping || rollback) begin
            // stay in discard until the closing word goes by
            dropping <= !in_s.tlast;
            if (in_s.tlast) begin
               drop_cnt <= drop_cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* hdl/axis_probe.sv */
// Stream probe
// Watches one stream and keeps running totals of packets
// (handshakes with tlast) and bytes (set tkeep lanes per handshake)

`timescale 1ns/1ps

module axis_probe (
   input  logic                            aclk,
   input  logic                            rst_n,
   axis_if.monitor                         axis,
   output logic [pkt_fifo_pkg::cnt_w-1:0]  pkt_cnt,
   output logic [pkt_fifo_pkg::cnt_w-1:0]  byte_cnt
);

   logic                            xfer;
   logic [pkt_fifo_pkg::cnt_w-1:0]  lane_cnt;

   // a word moves only when both sides agree
   assign xfer = axis.tvalid && axis.tready;

   // number of valid byte lanes in the current word
   assign lane_cnt = pkt_fifo_pkg::cnt_w'($countones(axis.tkeep));

   // --------------------------------------------------
   // counters
   // --------------------------------------------------
   // packet count, bumped on the closing word
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_cnt <= '0;
      end else if (xfer && axis.tlast) begin
         pkt_cnt <= pkt_cnt + 1'b1;
      end
   end

   // byte count, every word contributes its lane count
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         byte_cnt <= '0;
      end else if (xfer) begin
         byte_cnt <= byte_cnt + lane_cnt;
      end
   end

   // counters wrap silently; software reads differences

endmodule

/* common/axis_if.sv */
// Byte-lane stream interface
// Carries tvalid, tready, tdata, tkeep and tlast on the aclk domain.
// A word moves on a rising edge with tvalid and tready both high

`timescale 1ns/1ps

interface axis_if;

   logic                              tvalid;
   logic                              tready;
   logic [pkt_fifo_pkg::data_w-1:0]   tdata;
   logic [pkt_fifo_pkg::keep_w-1:0]   tkeep;
   logic                              tlast;

   // source side
   modport tx (
      output tvalid, tdata, tkeep, tlast,
      input  tready
   );

   // sink side, owns back-pressure
   modport rx (
      input  tvalid, tdata, tkeep, tlast,
      output tready
   );

   // passive taps such as the probes
   modport monitor (
      input tvalid, tready, tdata, tkeep, tlast
   );

endinterface

/* common/pkt_fifo_pkg.sv */
// Packet FIFO shared definitions
// Stream widths, statistics counter width, the stored word layout
// and the APB register map used by the register block

package pkt_fifo_pkg;

   // --------------------------------------------------
   // stream widths
   // --------------------------------------------------
   localparam int data_bytes = 4;
   localparam int data_w     = data_bytes * 8;
   localparam int keep_w     = data_bytes;

   // statistics counters, wide enough to run for a long time
   localparam int cnt_w = 32;

   // one word as it sits in the store
   typedef struct packed {
      logic              tlast;
      logic [keep_w-1:0] tkeep;
      logic [data_w-1:0] tdata;
   } stream_word_t;

   // --------------------------------------------------
   // APB register map, byte offsets
   // --------------------------------------------------
   localparam int apb_addr_w = 8;

   localparam logic [apb_addr_w-1:0] reg_in_pkts   = 8'h00;
   localparam logic [apb_addr_w-1:0] reg_in_bytes  = 8'h04;
   localparam logic [apb_addr_w-1:0] reg_out_pkts  = 8'h08;
   localparam logic [apb_addr_w-1:0] reg_out_bytes = 8'h0C;
   localparam logic [apb_addr_w-1:0] reg_drop_pkts = 8'h10;
   // committed words not yet read
   localparam logic [apb_addr_w-1:0] reg_level     = 8'h14;

endpackage
